//--- verification/pin_array_stimulus.txt
# columns: op ch offset data expect, all hex. ops: 1 write, 2 read (data masks), 3 sample (data masks)
# 4 set current_time, 5 set pin_in, 6 wait cycles, 7 count toggles (data is window), 8 pin_oe, 9 pin_out, a read minimum
8 0 00 f 0
2 0 08 ffff 0800
2 3 08 00ff 0003
2 2 08 ffff 0802
1 1 02 deadbeef 0
2 1 09 ffff beef
2 1 0a ffff 0
2 7 08 ffff 0
4 0 00 100 0
1 0 02 200 0
1 0 03 2 0
6 0 00 2 0
8 0 00 1 1
9 0 00 1 1
2 0 08 f800 1000
4 0 00 200 0
6 0 00 2 0
2 0 08 ffff 0800
8 0 00 1 0
1 1 02 ffffffff 0
1 1 01 10000000 0
1 1 03 1 0
6 0 00 4 0
7 1 00 100 20
1 1 03 5 0
6 0 00 2 0
2 1 08 ffff 0801
8 0 00 2 0
5 0 00 4 0
1 2 04 4 0
1 2 03 3 0
6 0 00 10 0
2 2 05 ffff 1
6 0 00 40 0
a 2 07 0 e
3 2 00 ffff abcf
3 0 00 ffffffff abce
3 9 00 ffffffff 0
1 2 03 5 0
6 0 00 2 0
2 2 08 ffff 0802
5 0 00 0 0

//--- project.f
+incdir+include
src/pin_ctrl_pkg.sv
src/reg_bus_if.sv
src/reg_bus_fabric.sv
src/pin_channel.sv
src/sample_collector.sv
src/pin_array.sv
verification/pin_array_properties.sv
verification/pin_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pin_array testbench with Verilator.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Mdir obj_dir -f project.f \
  --top-module pin_array_tb -o pin_array_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/pin_array_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
  exit 1
fi
exit 0

//--- verification/pin_array_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "pin_ctrl_params.svh"

module pin_array_tb;

  localparam int clk_period = 4;
  localparam int max_ops = 256;

  logic                         clk;
  logic                         reset;
  logic                         enable;
  logic [18:0]                  addr;
  logic                         data_wr;
  logic                         data_rd;
  logic [31:0]                  data_in;
  logic [15:0]                  data_out;
  logic [31:0]                  current_time;
  logic [`PIN_NUM_CHANNELS-1:0] pin_in;
  logic [`PIN_NUM_CHANNELS-1:0] pin_out;
  logic [`PIN_NUM_CHANNELS-1:0] pin_oe;
  logic                         output_sample;
  logic [7:0]                   channel_select;
  logic [31:0]                  sample_data;

  // one stimulus entry per index.
  logic [31:0] op_code [max_ops];
  logic [31:0] op_ch [max_ops];
  logic [31:0] op_off [max_ops];
  logic [31:0] op_data [max_ops];
  logic [31:0] op_exp [max_ops];
  int          num_ops = 0;
  int          error_count = 0;
  int          watchdog_cycles = 0;

  pin_array dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      error_count++;
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_ch;
    logic [31:0] f_off;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    fd = $fopen("verification/pin_array_stimulus.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open the stimulus file verification/pin_array_stimulus.txt");
      return;
    end
    while (!$feof(fd) && num_ops < max_ops) begin
      n = $fgets(line, fd);
      // comment and blank lines do not scan as five fields.
      n = $sscanf(line, "%h %h %h %h %h", f_op, f_ch, f_off, f_data, f_exp);
      if (n == 5) begin
        op_code[num_ops] = f_op;
        op_ch[num_ops]   = f_ch;
        op_off[num_ops]  = f_off;
        op_data[num_ops] = f_data;
        op_exp[num_ops]  = f_exp;
        num_ops++;
      end
    end
    $fclose(fd);
  endtask

  task automatic bus_write(input logic [7:0] ch, input logic [7:0] off, input logic [31:0] data);
    addr    = {3'b000, ch, off};
    data_in = data;
    enable  = 1'b1;
    data_wr = 1'b1;
    @(negedge clk);
    enable  = 1'b0;
    data_wr = 1'b0;
  endtask

  // data_out holds for the cycle after the read strobe.
  task automatic bus_read(input logic [7:0] ch, input logic [7:0] off, output logic [31:0] got);
    addr    = {3'b000, ch, off};
    enable  = 1'b1;
    data_rd = 1'b1;
    @(negedge clk);
    got     = {16'b0, data_out};
    enable  = 1'b0;
    data_rd = 1'b0;
  endtask

  task automatic sample_request(input logic [7:0] ch, output logic [31:0] got);
    channel_select = ch;
    output_sample  = 1'b1;
    @(negedge clk);
    got            = sample_data;
    output_sample  = 1'b0;
  endtask

  task automatic count_toggles(input int ch, input logic [31:0] window, output logic [31:0] count);
    logic prev;
    count = '0;
    prev  = pin_out[ch];
    repeat (window) begin
      @(negedge clk);
      if (pin_out[ch] !== prev) begin
        count = count + 32'd1;
      end
      prev = pin_out[ch];
    end
  endtask

  task automatic run_op(input int idx);
    logic [31:0] ch;
    logic [31:0] off;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] got;
    string       tag;
    ch       = op_ch[idx];
    off      = op_off[idx];
    data     = op_data[idx];
    expected = op_exp[idx];
    tag      = $sformatf("entry %0d ch %0d off %h", idx, ch, off[7:0]);
    case (op_code[idx])
      32'h1: bus_write(ch[7:0], off[7:0], data);
      32'h2: begin
        bus_read(ch[7:0], off[7:0], got);
        check_value(got & data, expected, {tag, " read"});
      end
      32'h3: begin
        sample_request(ch[7:0], got);
        check_value(got & data, expected, {tag, " sample record"});
      end
      32'h4: current_time = data;
      32'h5: pin_in = data[`PIN_NUM_CHANNELS-1:0];
      32'h6: repeat (data) @(negedge clk);
      // toggle count is allowed to be off by one.
      32'h7: begin
        count_toggles(int'(ch[1:0]), data, got);
        check_value((got + 32'd1 >= expected && got <= expected + 32'd1) ? expected : got,
                    expected, {tag, " pin_out toggles"});
      end
      32'h8: check_value({28'b0, pin_oe} & data, expected, {tag, " pin_oe"});
      32'h9: check_value({28'b0, pin_out} & data, expected, {tag, " pin_out"});
      32'ha: begin
        bus_read(ch[7:0], off[7:0], got);
        check_value((got >= expected) ? expected : got, expected, {tag, " read minimum"});
      end
      default: begin
        error_count++;
        $display("stimulus entry %0d has an unknown operation code %h", idx, op_code[idx]);
      end
    endcase
  endtask

  initial begin
    reset          = 1'b1;
    enable         = 1'b0;
    addr           = '0;
    data_wr        = 1'b0;
    data_rd        = 1'b0;
    data_in        = '0;
    current_time   = '0;
    pin_in         = '0;
    output_sample  = 1'b0;
    channel_select = '0;
    load_stimulus();
    // waits and toggle windows set the run length.
    watchdog_cycles = 200;
    for (int i = 0; i < num_ops; i++) begin
      watchdog_cycles += 4;
      if (op_code[i] == 32'h6 || op_code[i] == 32'h7) begin
        watchdog_cycles += int'(op_data[i]);
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < num_ops; i++) begin
      run_op(i);
    end
    @(negedge clk);
    $display("%0d entries run, %0d check errors, %0d assertion failures",
             num_ops, error_count, dut0.props0.assert_fails);
    if (error_count == 0 && dut0.props0.assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the stimulus did not finish within %0d cycles", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/pin_array_properties.sv
`timescale 1ns/1ns
`default_nettype none
`include "pin_ctrl_params.svh"

module pin_array_properties (
  input logic                         clk,
  input logic                         reset,
  input logic                         enable,
  input logic                         data_rd,
  input logic [18:0]                  addr,
  input logic [15:0]                  data_out,
  input logic                         output_sample,
  input logic [7:0]                   channel_select,
  input logic [31:0]                  sample_data,
  input logic [`PIN_NUM_CHANNELS-1:0] pin_oe
);

  int unsigned assert_fails = 0;

  // no pin driven once reset has been seen.
  oe_after_reset: assert property (@(posedge clk) reset |=> (pin_oe == '0))
    else begin
      assert_fails++;
      $error("pin_oe is set on the cycle after reset");
    end

  // status of an existing page comes back from that page alone, in one state.
  status_page: assert property (@(posedge clk) disable iff (reset)
                                (enable && data_rd && addr[7:0] == `PIN_REG_STATUS &&
                                 addr[15:8] < 8'(`PIN_NUM_CHANNELS))
                                |=> (data_out[7:0] == $past(addr[15:8]) &&
                                     $onehot(data_out[15:11])))
    else begin
      assert_fails++;
      $error("status read returns the wrong page or more than one state");
    end

  // a request for an existing channel returns a real record.
  sample_marker: assert property (@(posedge clk) disable iff (reset)
                                  (output_sample &&
                                   channel_select < 8'(`PIN_NUM_CHANNELS))
                                  |=> (sample_data[15:1] == `PIN_SAMPLE_MARKER &&
                                       !sample_data[31]))
    else begin
      assert_fails++;
      $error("sample_data lacks the record marker for a valid channel");
    end

endmodule

bind pin_array pin_array_properties props0 (
  .clk            (clk),
  .reset          (reset),
  .enable         (enable),
  .data_rd        (data_rd),
  .addr           (addr),
  .data_out       (data_out),
  .output_sample  (output_sample),
  .channel_select (channel_select),
  .sample_data    (sample_data),
  .pin_oe         (pin_oe)
);

`default_nettype wire

//--- src/pin_array.sv
`timescale 1ns/1ns
`default_nettype none
`include "pin_ctrl_params.svh"

module pin_array (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic [18:0]                  addr,
  input  logic                         data_wr,
  input  logic                         data_rd,
  input  logic [31:0]                  data_in,
  output logic [15:0]                  data_out,
  input  logic [31:0]                  current_time,
  input  logic [`PIN_NUM_CHANNELS-1:0] pin_in,
  output logic [`PIN_NUM_CHANNELS-1:0] pin_out,
  output logic [`PIN_NUM_CHANNELS-1:0] pin_oe,
  input  logic                         output_sample,
  input  logic [7:0]                   channel_select,
  output logic [31:0]                  sample_data
);

  reg_bus_if   bus [`PIN_NUM_CHANNELS] ();
  logic [31:0] records [`PIN_NUM_CHANNELS];

  reg_bus_fabric u_fabric (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .addr     (addr),
    .data_wr  (data_wr),
    .data_rd  (data_rd),
    .data_in  (data_in),
    .data_out (data_out),
    .ch       (bus)
  );

  for (genvar i = 0; i < `PIN_NUM_CHANNELS; i++) begin : g_channel
    pin_channel #(
      .position (i)
    ) u_channel (
      .clk           (clk),
      .reset         (reset),
      .bus           (bus[i]),
      .current_time  (current_time),
      .pin_in        (pin_in[i]),
      .pin_out       (pin_out[i]),
      .pin_oe        (pin_oe[i]),
      .sample_record (records[i])
    );
  end

  sample_collector u_collector (
    .clk            (clk),
    .reset          (reset),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .records        (records),
    .sample_data    (sample_data)
  );

endmodule

`default_nettype wire

//--- src/sample_collector.sv
`timescale 1ns/1ns
`default_nettype none
`include "pin_ctrl_params.svh"

module sample_collector (
  input  logic        clk,
  input  logic        reset,
  input  logic        output_sample,
  input  logic [7:0]  channel_select,
  input  logic [31:0] records [`PIN_NUM_CHANNELS],
  output logic [31:0] sample_data
);

  // zero unless a request hits an existing channel.
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_data <= '0;
    end else begin
      sample_data <= '0;
      if (output_sample) begin
        for (int i = 0; i < `PIN_NUM_CHANNELS; i++) begin
          if (channel_select == 8'(i)) begin
            sample_data <= records[i];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/pin_channel.sv
`timescale 1ns/1ns
`default_nettype none
`include "pin_ctrl_params.svh"

module pin_channel #(
  parameter int position = 0
) (
  input  logic        clk,
  input  logic        reset,
  reg_bus_if.channel  bus,
  input  logic [31:0] current_time,
  input  logic        pin_in,
  output logic        pin_out,
  output logic        pin_oe,
  output logic [31:0] sample_record
);

  localparam logic [7:0] pos_id = 8'(position);

  logic [31:0] nco_inc;
  logic [31:0] end_time;
  logic [31:0] nco_pa;
  logic [15:0] command;
  logic [15:0] sample_rate;
  logic [15:0] rate_cnt;
  logic [15:0] last_data;
  logic [14:0] sample_cnt;
  logic [4:0]  state;
  logic [7:0]  offset;
  logic        sample_level;
  logic        cmd_clear;
  logic        cmd_pending;
  logic        stream_start;
  logic        wr_en;
  logic        rd_en;
  logic        pin_meta;
  logic        pin_sync;

  assign offset       = bus.addr.f.offset;
  assign wr_en        = bus.sel && bus.wr;
  assign rd_en        = bus.sel && bus.rd;
  assign cmd_pending  = (command != '0) && !cmd_clear;
  assign stream_start = (state == `PIN_ST_IDLE) && cmd_pending &&
                        (command == `PIN_CMD_INPUT_STREAM);

  // a host write to the command register wins over the one-shot clear.
  always_ff @(posedge clk) begin
    if (reset) begin
      nco_inc     <= '0;
      end_time    <= '0;
      command     <= '0;
      sample_rate <= '0;
    end else begin
      if (cmd_clear) begin
        command <= '0;
      end
      if (wr_en) begin
        case (offset)
          `PIN_REG_NCO_INC:     nco_inc <= bus.wdata;
          `PIN_REG_END_TIME:    end_time <= bus.wdata;
          `PIN_REG_LOCAL_CMD:   command <= bus.wdata[15:0];
          `PIN_REG_SAMPLE_RATE: sample_rate <= bus.wdata[15:0];
          default: ;
        endcase
      end
    end
  end

  // capture of any write to this page.
  always_ff @(posedge clk) begin
    if (reset) begin
      last_data <= '0;
    end else if (wr_en) begin
      last_data <= bus.wdata[15:0];
    end
  end

  // command fsm.
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= `PIN_ST_IDLE;
      cmd_clear <= 1'b0;
    end else begin
      cmd_clear <= 1'b0;
      case (state)
        `PIN_ST_IDLE: begin
          if (cmd_pending) begin
            cmd_clear <= 1'b1;
            case (command)
              `PIN_CMD_START_OUTPUT: state <= `PIN_ST_OUTPUT;
              `PIN_CMD_CONST:        state <= `PIN_ST_CONST;
              `PIN_CMD_INPUT_STREAM: state <= `PIN_ST_STREAM;
              default: ;
            endcase
          end
        end
        `PIN_ST_OUTPUT, `PIN_ST_CONST: begin
          if (cmd_pending && (command == `PIN_CMD_RESET)) begin
            cmd_clear <= 1'b1;
            state     <= `PIN_ST_IDLE;
          end else if (current_time >= end_time) begin
            state <= `PIN_ST_IDLE;
          end
        end
        // streaming runs until a reset command.
        `PIN_ST_STREAM: begin
          if (cmd_pending && (command == `PIN_CMD_RESET)) begin
            cmd_clear <= 1'b1;
            state     <= `PIN_ST_IDLE;
          end
        end
        default: state <= `PIN_ST_IDLE;
      endcase
    end
  end

  // nco output frequency is roughly f_clk * nco_inc / 2^32.
  always_ff @(posedge clk) begin
    if (reset) begin
      nco_pa <= '0;
    end else if (state == `PIN_ST_OUTPUT) begin
      nco_pa <= nco_pa + nco_inc;
    end else if (state == `PIN_ST_CONST) begin
      nco_pa <= '1;
    end else begin
      nco_pa <= '0;
    end
  end

  assign pin_out = nco_pa[31];
  assign pin_oe  = (state == `PIN_ST_OUTPUT) || (state == `PIN_ST_CONST);

  // two-stage sync for the asynchronous pin.
  always_ff @(posedge clk) begin
    pin_meta <= pin_in;
    pin_sync <= pin_meta;
  end

  // input sampler takes one sample every sample_rate cycles.
  always_ff @(posedge clk) begin
    if (reset) begin
      rate_cnt     <= '0;
      sample_cnt   <= '0;
      sample_level <= 1'b0;
    end else if (stream_start) begin
      rate_cnt     <= sample_rate;
      sample_cnt   <= '0;
      sample_level <= 1'b0;
    end else if (state == `PIN_ST_STREAM) begin
      if (rate_cnt <= 16'd1) begin
        rate_cnt     <= sample_rate;
        sample_level <= pin_sync;
        sample_cnt   <= sample_cnt + 15'd1;
      end else begin
        rate_cnt <= rate_cnt - 16'd1;
      end
    end
  end

  // registered read data is zero when not addressed.
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata <= '0;
    end else if (rd_en) begin
      case (offset)
        `PIN_REG_SAMPLE_LEVEL: bus.rdata <= {15'b0, sample_level};
        `PIN_REG_SAMPLE_CNT:   bus.rdata <= {1'b0, sample_cnt};
        `PIN_REG_STATUS:       bus.rdata <= {state, 3'b000, pos_id};
        `PIN_REG_LAST_DATA:    bus.rdata <= last_data;
        default:               bus.rdata <= '0;
      endcase
    end else begin
      bus.rdata <= '0;
    end
  end

  assign sample_record = {1'b0, sample_cnt, `PIN_SAMPLE_MARKER, sample_level};

endmodule

`default_nettype wire

//--- src/reg_bus_fabric.sv
`timescale 1ns/1ns
`default_nettype none
`include "pin_ctrl_params.svh"

module reg_bus_fabric (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable,
  input  pin_ctrl_pkg::bus_addr_u addr,
  input  logic                  data_wr,
  input  logic                  data_rd,
  input  logic [31:0]           data_in,
  output logic [15:0]           data_out,
  reg_bus_if.fabric             ch [`PIN_NUM_CHANNELS]
);

  logic [15:0] rdata_ch [`PIN_NUM_CHANNELS];
  logic        rd_pending;

  // page match selects exactly one channel.
  for (genvar i = 0; i < `PIN_NUM_CHANNELS; i++) begin : g_ch
    assign ch[i].sel   = enable && (addr.f.page == 8'(i));
    assign ch[i].wr    = data_wr;
    assign ch[i].rd    = data_rd;
    assign ch[i].addr  = addr;
    assign ch[i].wdata = data_in;
    assign rdata_ch[i] = ch[i].rdata;
  end

  // read data is valid the cycle after the strobe.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= enable && data_rd;
    end
  end

  always_comb begin
    data_out = '0;
    if (rd_pending) begin
      for (int k = 0; k < `PIN_NUM_CHANNELS; k++) begin
        data_out = data_out | rdata_ch[k];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/reg_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface reg_bus_if;
  import pin_ctrl_pkg::*;

  logic        sel;
  logic        wr;
  logic        rd;
  bus_addr_u   addr;
  logic [31:0] wdata;
  logic [15:0] rdata;

  modport fabric (output sel, output wr, output rd, output addr, output wdata,
                  input rdata);

  modport channel (input sel, input wr, input rd, input addr, input wdata,
                   output rdata);

endinterface

`default_nettype wire

//--- src/pin_ctrl_pkg.sv
`default_nettype none

package pin_ctrl_pkg;

  // host bus address, seen as one word or as page and register offset.
  typedef union packed {
    logic [18:0] raw;
    struct packed {
      logic [2:0] spare;
      logic [7:0] page;
      logic [7:0] offset;
    } f;
  } bus_addr_u;

endpackage

`default_nettype wire

//--- include/pin_ctrl_params.svh
`ifndef PIN_CTRL_PARAMS_SVH
`define PIN_CTRL_PARAMS_SVH

// channels in the bank.
`define PIN_NUM_CHANNELS 4

// register byte offsets within a channel page.
`define PIN_REG_NCO_INC      8'd1
`define PIN_REG_END_TIME     8'd2
`define PIN_REG_LOCAL_CMD    8'd3
`define PIN_REG_SAMPLE_RATE  8'd4
`define PIN_REG_SAMPLE_LEVEL 8'd5
`define PIN_REG_SAMPLE_CNT   8'd7
`define PIN_REG_STATUS       8'd8
`define PIN_REG_LAST_DATA    8'd9

// one-shot command codes.
`define PIN_CMD_START_OUTPUT 16'd1
`define PIN_CMD_CONST        16'd2
`define PIN_CMD_INPUT_STREAM 16'd3
`define PIN_CMD_RESET        16'd5

// one-hot channel states, as seen in status bits 15:11.
`define PIN_ST_IDLE   5'b00001
`define PIN_ST_CONST  5'b00010
`define PIN_ST_STREAM 5'b01000
`define PIN_ST_OUTPUT 5'b10000

// fixed marker field of a sample record.
`define PIN_SAMPLE_MARKER 15'h55E7

`endif
